//--- common/bp_defines.svh
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// fetch width, two instructions per cycle
`define NUM_SUPER 2

// table geometry
`define NUM_BH_IDX_BITS 4                        // 16 entries per table
`define NUM_BH_ENTRIES  (1 << `NUM_BH_IDX_BITS)

// alpha major opcodes, inst[31:26]
// unconditional group
`define BR_INST   6'h30
`define BSR_INST  6'h34
`define JSR_GRP   6'h1a                          // jmp/jsr/ret/jsr_co share this opcode

// conditional integer branches
`define BLBC_INST 6'h38
`define BEQ_INST  6'h39
`define BLT_INST  6'h3a
`define BLE_INST  6'h3b
`define BLBS_INST 6'h3c
`define BNE_INST  6'h3d
`define BGE_INST  6'h3e
`define BGT_INST  6'h3f

// counter state after reset
`define BHT_RESET_CTR 2'b01                      // weakly not-taken

`endif

//--- common/bp_pkg.sv
`include "bp_defines.svh"

package bp_pkg;

  // program counter and next-pc values
  typedef logic [63:0] addr_t;

  // raw fetched instruction word
  typedef logic [31:0] inst_t;

  // major opcode field, inst[31:26]
  typedef logic [5:0] opcode_t;

  // table index, sliced from addr[NUM_BH_IDX_BITS+1:2]
  // low two address bits are always zero for aligned insts
  typedef logic [`NUM_BH_IDX_BITS-1:0] bh_idx_t;

  // 2-bit saturating counter
  //   00 strongly not-taken
  //   01 weakly not-taken
  //   10 weakly taken
  //   11 strongly taken
  // upper bit alone gives the direction
  typedef logic [1:0] counter_t;

  // one bit per fetch or resolve lane
  typedef logic [`NUM_SUPER-1:0] lane_mask_t;

endpackage

//--- branch_predictor/bht.sv
`timescale 1ns/100ps

`include "bp_defines.svh"

// branch history table
// one 2-bit saturating counter per index, no tags
// lookups see this cycle's training (write-through)
module bht import bp_pkg::*; (
  input  logic                          clock,
  input  logic                          reset,
  input  bh_idx_t    [`NUM_SUPER-1:0]   lookup_idx,    // fetch side index per lane
  input  lane_mask_t                    update_valid,  // resolved branch on this lane
  input  lane_mask_t                    update_taken,  // its actual direction
  input  bh_idx_t    [`NUM_SUPER-1:0]   update_idx,    // resolve side index per lane
  output counter_t   [`NUM_SUPER-1:0]   lookup_ctr
);

  counter_t ctr_q    [`NUM_BH_ENTRIES];  // registered counters
  counter_t ctr_next [`NUM_BH_ENTRIES];  // counters after this cycle's resolves

  // step a counter one position toward the resolved direction
  function automatic counter_t sat_update(input counter_t ctr, input logic taken);
    counter_t result;
    if (taken) begin
      result = (ctr == 2'b11) ? ctr : ctr + 2'b01;  // hold at strongly taken
    end else begin
      result = (ctr == 2'b00) ? ctr : ctr - 2'b01;  // hold at strongly not-taken
    end
    return result;
  endfunction

  // next table
  // every lane steps from the registered value, not from another lane's result
  // later lanes overwrite earlier ones, so lane 1 wins a shared index
  always_comb begin
    ctr_next = ctr_q;
    for (int i = 0; i < `NUM_SUPER; i++) begin
      if (update_valid[i]) begin
        ctr_next[update_idx[i]] = sat_update(ctr_q[update_idx[i]], update_taken[i]);
      end
    end
  end

  // lookups read the next table
  always_comb begin
    for (int i = 0; i < `NUM_SUPER; i++) begin
      lookup_ctr[i] = ctr_next[lookup_idx[i]];  // bypasses same-cycle training
    end
  end

  // counter storage
  always_ff @(posedge clock) begin
    if (reset) begin
      ctr_q <= '{default: `BHT_RESET_CTR};  // all weakly not-taken
    end else begin
      ctr_q <= ctr_next;
    end
  end

endmodule

//--- branch_predictor/btb.sv
`timescale 1ns/100ps

`include "bp_defines.svh"

// branch target buffer
// direct mapped, untagged, one target plus valid bit per index
// only taken resolves write, so an entry holds the last taken target seen
module btb import bp_pkg::*; (
  input  logic                          clock,
  input  logic                          reset,
  input  bh_idx_t    [`NUM_SUPER-1:0]   lookup_idx,     // fetch side index per lane
  input  lane_mask_t                    update_en,      // resolved and taken
  input  bh_idx_t    [`NUM_SUPER-1:0]   update_idx,     // resolve side index per lane
  input  addr_t      [`NUM_SUPER-1:0]   update_target,  // resolved target address
  output lane_mask_t                    lookup_hit,     // entry has been written since reset
  output addr_t      [`NUM_SUPER-1:0]   lookup_target
);

  addr_t target_q    [`NUM_BH_ENTRIES];  // stored targets
  addr_t target_next [`NUM_BH_ENTRIES];
  logic  valid_q     [`NUM_BH_ENTRIES];  // entry written at least once
  logic  valid_next  [`NUM_BH_ENTRIES];

  // next arrays
  // lane order gives lane 1 the last word on a shared index
  always_comb begin
    target_next = target_q;
    valid_next  = valid_q;
    for (int i = 0; i < `NUM_SUPER; i++) begin
      if (update_en[i]) begin
        target_next[update_idx[i]] = update_target[i];
        valid_next[update_idx[i]]  = 1'b1;  // once set, stays set until reset
      end
    end
  end

  // lookup from the next arrays
  // a taken resolve this cycle is visible to this cycle's fetch
  always_comb begin
    for (int i = 0; i < `NUM_SUPER; i++) begin
      lookup_hit[i]    = valid_next[lookup_idx[i]];
      lookup_target[i] = target_next[lookup_idx[i]];
    end
  end

  // storage
  always_ff @(posedge clock) begin
    if (reset) begin
      target_q <= '{default: '0};
      valid_q  <= '{default: 1'b0};  // nothing predicted taken after reset
    end else begin
      target_q <= target_next;
      valid_q  <= valid_next;
    end
  end

endmodule

//--- branch_predictor/predict_select.sv
`timescale 1ns/100ps

`include "bp_defines.svh"

// prediction selector
// decodes branch opcodes per lane and merges direction, btb hit and rollback
// purely combinational, answers in the same cycle as fetch
module predict_select import bp_pkg::*; (
  input  inst_t      [`NUM_SUPER-1:0]   fetch_inst,
  input  lane_mask_t                    fetch_valid,      // per lane, low means garbage
  input  logic                          rollback,         // mispredict recovery from fus
  input  addr_t                         rollback_target,  // resolved correct pc
  input  counter_t   [`NUM_SUPER-1:0]   lookup_ctr,       // from bht
  input  lane_mask_t                    lookup_hit,       // from btb
  input  addr_t      [`NUM_SUPER-1:0]   lookup_target,    // from btb
  output lane_mask_t                    pred_branch,
  output lane_mask_t                    pred_taken,
  output addr_t                         pred_target
);

  opcode_t    [`NUM_SUPER-1:0] opcode;     // major opcode per lane
  lane_mask_t                  is_cond;    // conditional integer branch
  lane_mask_t                  is_uncond;  // br, bsr or jump group

  // opcode decode
  // classification ignores fetch_valid, that gating happens below
  always_comb begin
    for (int i = 0; i < `NUM_SUPER; i++) begin
      opcode[i]    = fetch_inst[i][31:26];
      is_cond[i]   = 1'b0;
      is_uncond[i] = 1'b0;
      case (opcode[i])
        `BLBC_INST, `BEQ_INST, `BLT_INST, `BLE_INST,
        `BLBS_INST, `BNE_INST, `BGE_INST, `BGT_INST: begin
          is_cond[i] = 1'b1;
        end
        `BR_INST, `BSR_INST, `JSR_GRP: begin
          is_uncond[i] = 1'b1;
        end
        default: begin
          // not a branch
        end
      endcase
    end
  end

  // branch flag and direction per lane
  always_comb begin
    for (int i = 0; i < `NUM_SUPER; i++) begin
      // a lane is a branch only when fetched cleanly and not being flushed
      pred_branch[i] = fetch_valid[i] && !rollback && (is_cond[i] || is_uncond[i]);
      // taken needs a known target, then counter msb for conditionals
      pred_taken[i]  = rollback ||
                       (pred_branch[i] && lookup_hit[i] && (is_uncond[i] || lookup_ctr[i][1]));
    end
  end

  // single redirect target
  // walk lanes high to low so the lowest taken lane is left standing
  always_comb begin
    pred_target = '0;  // nothing taken
    for (int i = `NUM_SUPER - 1; i >= 0; i--) begin
      if (pred_taken[i]) begin
        pred_target = lookup_target[i];
      end
    end
    if (rollback) begin
      pred_target = rollback_target;  // recovery beats any prediction
    end
  end

endmodule

//--- branch_predictor/branch_predictor.sv
`timescale 1ns/100ps

`include "bp_defines.svh"

// branch predictor top
// bht and btb look up side by side, predict_select forms the fetch answer
module branch_predictor import bp_pkg::*; (
  input  logic                          clock,
  input  logic                          reset,
  // fetch side
  input  addr_t      [`NUM_SUPER-1:0]   fetch_npc,
  input  inst_t      [`NUM_SUPER-1:0]   fetch_inst,
  input  lane_mask_t                    fetch_valid,
  // functional unit side
  input  logic                          rollback,
  input  addr_t                         rollback_target,
  input  lane_mask_t                    resolve_valid,    // a branch resolved on this lane
  input  lane_mask_t                    resolve_taken,
  input  addr_t      [`NUM_SUPER-1:0]   resolve_npc,      // indexes training like fetch does
  input  addr_t      [`NUM_SUPER-1:0]   resolve_target,
  // to fetch
  output lane_mask_t                    pred_branch,
  output lane_mask_t                    pred_taken,
  output addr_t                         pred_target
);

  bh_idx_t    [`NUM_SUPER-1:0] fetch_idx;    // shared by both tables
  bh_idx_t    [`NUM_SUPER-1:0] resolve_idx;
  lane_mask_t                  btb_update_en;
  counter_t   [`NUM_SUPER-1:0] lookup_ctr;
  lane_mask_t                  lookup_hit;
  addr_t      [`NUM_SUPER-1:0] lookup_target;

  // index from word address bits, once for both tables
  always_comb begin
    for (int i = 0; i < `NUM_SUPER; i++) begin
      fetch_idx[i]   = fetch_npc[i][`NUM_BH_IDX_BITS+1:2];
      resolve_idx[i] = resolve_npc[i][`NUM_BH_IDX_BITS+1:2];
    end
  end

  assign btb_update_en = resolve_valid & resolve_taken;  // only taken branches fill the btb

  bht u_bht (
    .clock        (clock),
    .reset        (reset),
    .lookup_idx   (fetch_idx),
    .update_valid (resolve_valid),
    .update_taken (resolve_taken),
    .update_idx   (resolve_idx),
    .lookup_ctr   (lookup_ctr)
  );

  btb u_btb (
    .clock         (clock),
    .reset         (reset),
    .lookup_idx    (fetch_idx),
    .update_en     (btb_update_en),
    .update_idx    (resolve_idx),
    .update_target (resolve_target),
    .lookup_hit    (lookup_hit),
    .lookup_target (lookup_target)
  );

  predict_select u_select (
    .fetch_inst      (fetch_inst),
    .fetch_valid     (fetch_valid),
    .rollback        (rollback),
    .rollback_target (rollback_target),
    .lookup_ctr      (lookup_ctr),
    .lookup_hit      (lookup_hit),
    .lookup_target   (lookup_target),
    .pred_branch     (pred_branch),
    .pred_taken      (pred_taken),
    .pred_target     (pred_target)
  );

endmodule

//--- test/bp_ref_model.svh
`ifndef BP_REF_MODEL_SVH
`define BP_REF_MODEL_SVH

// branch classes
localparam logic [1:0] CLS_NONE   = 2'd0;
localparam logic [1:0] CLS_COND   = 2'd1;
localparam logic [1:0] CLS_UNCOND = 2'd2;

counter_t m_ctr [`NUM_BH_ENTRIES];  // state as of the last rising edge
addr_t    m_tgt [`NUM_BH_ENTRIES];
logic     m_val [`NUM_BH_ENTRIES];
counter_t n_ctr [`NUM_BH_ENTRIES];  // state after this cycle's resolves
addr_t    n_tgt [`NUM_BH_ENTRIES];
logic     n_val [`NUM_BH_ENTRIES];

// word address bits above the byte offset
function automatic bh_idx_t model_index(input addr_t a);
  return a[`NUM_BH_IDX_BITS+1:2];
endfunction

function automatic logic [1:0] model_class(input inst_t inst);
  case (inst[31:26])
    `BR_INST, `BSR_INST, `JSR_GRP: return CLS_UNCOND;
    `BLBC_INST, `BEQ_INST, `BLT_INST, `BLE_INST,
    `BLBS_INST, `BNE_INST, `BGE_INST, `BGT_INST: return CLS_COND;
    default: return CLS_NONE;
  endcase
endfunction

task automatic model_reset();
  for (int e = 0; e < `NUM_BH_ENTRIES; e++) begin
    m_ctr[e] = `BHT_RESET_CTR;
    m_tgt[e] = '0;
    m_val[e] = 1'b0;
  end
endtask

// apply the cycle's resolves, each from the registered entry
task automatic model_train();
  bh_idx_t  idx;
  counter_t c;
  n_ctr = m_ctr;
  n_tgt = m_tgt;
  n_val = m_val;
  for (int l = 0; l < `NUM_SUPER; l++) begin  // higher lane written last
    idx = model_index(resolve_npc[l]);
    if (resolve_valid[l]) begin
      c = m_ctr[idx];
      if (resolve_taken[l] && c != 2'b11) c = c + 2'b01;
      else if (!resolve_taken[l] && c != 2'b00) c = c - 2'b01;
      n_ctr[idx] = c;
      if (resolve_taken[l]) begin
        n_tgt[idx] = resolve_target[l];
        n_val[idx] = 1'b1;
      end
    end
  end
endtask

// expected outputs from the trained view of the tables
task automatic model_predict(output lane_mask_t br, output lane_mask_t tk, output addr_t tgt);
  bh_idx_t    idx [`NUM_SUPER];
  logic [1:0] cls;
  logic       found;
  found = 1'b0;
  tgt   = '0;
  for (int l = 0; l < `NUM_SUPER; l++) begin
    idx[l] = model_index(fetch_npc[l]);
    cls    = model_class(fetch_inst[l]);
    br[l]  = fetch_valid[l] && !rollback && (cls != CLS_NONE);
    tk[l]  = rollback || (br[l] && n_val[idx[l]] && (cls == CLS_UNCOND || n_ctr[idx[l]][1]));
    if (tk[l] && !found) begin  // lowest taken lane redirects
      tgt   = n_tgt[idx[l]];
      found = 1'b1;
    end
  end
  if (rollback) tgt = rollback_target;
endtask

task automatic model_commit();
  m_ctr = n_ctr;
  m_tgt = n_tgt;
  m_val = n_val;
endtask

`endif

//--- test/tb_branch_predictor.sv
`timescale 1ns/100ps

`include "bp_defines.svh"

module tb_branch_predictor import bp_pkg::*; ();

  localparam int    RESET_CYCLES = 16;
  localparam int    TEST_CYCLES  = 2000;
  localparam int    IDLE_CYCLES  = 2;
  localparam int    SLACK_CYCLES = 50;
  localparam int    CLK_PERIOD   = 100;                     // ns
  localparam addr_t ADDR_BASE    = 64'h0000_0000_0012_0000;

  logic                        clock = 1'b0;
  logic                        reset;
  addr_t      [`NUM_SUPER-1:0] fetch_npc;
  inst_t      [`NUM_SUPER-1:0] fetch_inst;
  lane_mask_t                  fetch_valid;
  logic                        rollback;
  addr_t                       rollback_target;
  lane_mask_t                  resolve_valid;
  lane_mask_t                  resolve_taken;
  addr_t      [`NUM_SUPER-1:0] resolve_npc;
  addr_t      [`NUM_SUPER-1:0] resolve_target;
  lane_mask_t                  pred_branch;
  lane_mask_t                  pred_taken;
  addr_t                       pred_target;

  lane_mask_t  exp_branch;
  lane_mask_t  exp_taken;
  addr_t       exp_target;
  logic [31:0] lcg_state;
  int          num_checks = 0;

  `include "bp_ref_model.svh"

  always #(CLK_PERIOD / 2) clock = ~clock;

  branch_predictor u_dut (
    .clock           (clock),
    .reset           (reset),
    .fetch_npc       (fetch_npc),
    .fetch_inst      (fetch_inst),
    .fetch_valid     (fetch_valid),
    .rollback        (rollback),
    .rollback_target (rollback_target),
    .resolve_valid   (resolve_valid),
    .resolve_taken   (resolve_taken),
    .resolve_npc     (resolve_npc),
    .resolve_target  (resolve_target),
    .pred_branch     (pred_branch),
    .pred_taken      (pred_taken),
    .pred_target     (pred_target)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    return (lcg_next() >> 8) % n;  // low lcg bits cycle too fast
  endfunction

  // 24 word slots over 16 entries so indices collide a lot
  function automatic addr_t pick_addr();
    return ADDR_BASE + (addr_t'(rand_below(24)) << 2);
  endfunction

  function automatic addr_t pick_target();
    addr_t t;
    t = {lcg_next(), lcg_next()};
    t[1:0] = 2'b00;  // word aligned
    return t;
  endfunction

  function automatic inst_t pick_inst();
    opcode_t     op;
    logic [31:0] r;
    if (rand_below(100) < 60) begin
      case (rand_below(11))
        0:       op = `BR_INST;
        1:       op = `BSR_INST;
        2:       op = `JSR_GRP;
        3:       op = `BLBC_INST;
        4:       op = `BEQ_INST;
        5:       op = `BLT_INST;
        6:       op = `BLE_INST;
        7:       op = `BLBS_INST;
        8:       op = `BNE_INST;
        9:       op = `BGE_INST;
        default: op = `BGT_INST;
      endcase
    end else begin
      op = opcode_t'(lcg_next() >> 10);  // any opcode including branches
    end
    r = lcg_next();
    return {op, r[25:0]};
  endfunction

  // one cycle of random inputs driven at a rising edge
  task automatic drive_random();
    addr_t      [`NUM_SUPER-1:0] fnpc_v;
    inst_t      [`NUM_SUPER-1:0] inst_v;
    addr_t      [`NUM_SUPER-1:0] rnpc_v;
    addr_t      [`NUM_SUPER-1:0] rtgt_v;
    lane_mask_t                  fv;
    lane_mask_t                  rv;
    lane_mask_t                  rt;
    for (int l = 0; l < `NUM_SUPER; l++) begin
      fnpc_v[l] = pick_addr();
      inst_v[l] = pick_inst();
      rnpc_v[l] = pick_addr();
      rtgt_v[l] = pick_target();
      fv[l]     = rand_below(100) < 85;
      rv[l]     = rand_below(100) < 50;
      rt[l]     = rand_below(100) < 55;  // slight taken bias
    end
    fetch_npc       <= fnpc_v;
    fetch_inst      <= inst_v;
    fetch_valid     <= fv;
    resolve_npc     <= rnpc_v;
    resolve_target  <= rtgt_v;
    resolve_valid   <= rv;
    resolve_taken   <= rt;
    rollback        <= rand_below(100) < 5;
    rollback_target <= pick_target();
  endtask

  task automatic drive_idle();
    fetch_npc       <= '0;
    fetch_inst      <= '0;
    fetch_valid     <= '0;
    rollback        <= 1'b0;
    rollback_target <= '0;
    resolve_valid   <= '0;
    resolve_taken   <= '0;
    resolve_npc     <= '0;
    resolve_target  <= '0;
  endtask

  task automatic check_mask(input string field, input lane_mask_t got, input lane_mask_t exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %b expected %b", $time, field, got, exp);
      $display("Checks failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic check_target(input string field, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, field, got, exp);
      $display("Checks failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // outputs are settled mid cycle
  always @(negedge clock) begin
    if (reset) begin
      model_reset();
    end else begin
      model_train();
      model_predict(exp_branch, exp_taken, exp_target);
      check_mask("pred_branch", pred_branch, exp_branch);
      check_mask("pred_taken", pred_taken, exp_taken);
      check_target("pred_target", pred_target, exp_target);
      model_commit();  // rising edge registers the resolves
      num_checks++;
    end
  end

  initial begin
    lcg_state = 32'he237d54d;
    reset <= 1'b1;
    drive_idle();
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
    for (int c = 0; c < TEST_CYCLES; c++) begin
      drive_random();
      @(posedge clock);
    end
    drive_idle();
    repeat (IDLE_CYCLES) @(posedge clock);  // let the last random cycle be checked
    if (num_checks == TEST_CYCLES + IDLE_CYCLES) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Checks failed");
      $fatal(1, "run ended without the expected number of checked cycles");
    end
  end

  // watchdog
  initial begin
    #((RESET_CYCLES + TEST_CYCLES + SLACK_CYCLES) * CLK_PERIOD);
    $display("simulation timed out before the test sequence finished");
    $display("Checks failed");
    $fatal(1, "timeout");
  end

endmodule

//--- compile.f
+incdir+common
+incdir+test
common/bp_pkg.sv
branch_predictor/bht.sv
branch_predictor/btb.sv
branch_predictor/predict_select.sv
branch_predictor/branch_predictor.sv
test/tb_branch_predictor.sv

//--- run.sh
#!/bin/sh
# build and run the branch predictor testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_branch_predictor --Mdir obj_dir

out=$(./obj_dir/Vtb_branch_predictor) || true
echo "$out"

if echo "$out" | grep -q "All checks passed"; then
  exit 0
fi
exit 1
